// ==== design/rtg_defs.svh ====
//////////////////////////////////////////////////
// Widths and sizes of the RTG display path
// Included by the RTL files and the testbench
//////////////////////////////////////////////////
`ifndef RTG_DEFS_SVH
`define RTG_DEFS_SVH

// Memory side
`define RTG_ADDR_W 25	// Frame buffer byte address
`define RTG_DATA_W 16	// One memory word, one high-colour pixel

// Colour
`define COLOR_W 8	// Bits per channel
`define CLUT_ENTRIES 256	// Palette size, 8-bit index

// Fetch buffering
`define FIFO_DEPTH 16	// Words held ahead of the display

// Timing counters
`define PIXCTR_W 4	// Clocks per fetch minus one
`define VBCTR_W 7	// Extra vblank lines
`define NATIVE_DIV 8	// Native pixel period, halved in low res

// Config port
`define CFG_DATA_W 32

`endif

// ==== design/rtg_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the RTG display path
// Colour, native video, config writes, control bus
//////////////////////////////////////////////////
`default_nettype none

`include "rtg_defs.svh"

package rtg_pkg;

	// One display colour, 24 bits
	typedef struct packed {
		logic [`COLOR_W-1:0] r;
		logic [`COLOR_W-1:0] g;
		logic [`COLOR_W-1:0] b;
	} rgb_t;

	// Chipset video with its timing, 29 bits
	typedef struct packed {
		rgb_t rgb;
		logic hsync;
		logic vsync;
		logic csync;
		logic hblank;
		logic vblank;
	} native_video_t;

	// Register addresses of the config port
	typedef enum logic [2:0] {
		CFG_CONTROL     = 3'd0,	// Bit 0 enable, bit 1 CLUT mode
		CFG_BASE        = 3'd1,	// Frame buffer byte address
		CFG_PIXEL_WIDTH = 3'd2,	// Clocks per fetch minus one
		CFG_VBEND       = 3'd3,	// Lines added after vblank
		CFG_CLUT        = 3'd4	// Index 31..24, colour 23..0
	} cfg_reg_e;

	typedef struct packed {
		cfg_reg_e addr;
		logic [`CFG_DATA_W-1:0] data;
	} cfg_write_t;

	// Control bus to timer, FIFO and video out
	typedef struct packed {
		logic enable;
		logic clut_mode;
		logic [`PIXCTR_W-1:0] pixel_width;
		logic [`VBCTR_W-1:0] vbend;
		logic [`RTG_ADDR_W-1:0] base;
	} rtg_ctrl_t;

	typedef enum logic {
		FETCH_IDLE,	// Held at base address
		FETCH_RUN	// Streaming words
	} fetch_state_e;

endpackage

`default_nettype wire

// ==== design/rtg_config_regs.sv ====
//////////////////////////////////////////////////
// Config registers and palette RAM of the RTG path
// One write per cycle on cfg_valid, palette read
// returns one clock after the index
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rtg_defs.svh"

module rtg_config_regs import rtg_pkg::*; (
	input  wire logic                               CLK_114,
	input  wire logic                               reset,
	input  wire logic                               cfg_valid,	// Write strobe
	input  wire cfg_write_t                         cfg,
	input  wire logic [$clog2(`CLUT_ENTRIES)-1:0]   clut_idx,	// From video out
	output rtg_ctrl_t                               ctrl,
	output rgb_t                                    clut_rgb	// Registered colour
);

	localparam int IDX_W = $clog2(`CLUT_ENTRIES);

	rgb_t clut_mem [`CLUT_ENTRIES];	// Palette
	logic clut_we;

	assign clut_we = cfg_valid && (cfg.addr == CFG_CLUT);

	//////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			ctrl <= '0;	// RTG off
		end else if (cfg_valid) begin
			case (cfg.addr)
				CFG_CONTROL: begin
					ctrl.enable    <= cfg.data[0];
					ctrl.clut_mode <= cfg.data[1];
				end
				CFG_BASE:        ctrl.base <= {cfg.data[`RTG_ADDR_W-1:1], 1'b0};	// Word aligned
				CFG_PIXEL_WIDTH: ctrl.pixel_width <= cfg.data[`PIXCTR_W-1:0];
				CFG_VBEND:       ctrl.vbend <= cfg.data[`VBCTR_W-1:0];
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Palette RAM
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (clut_we)
			clut_mem[cfg.data[`CFG_DATA_W-1 -: IDX_W]] <= rgb_t'(cfg.data[3*`COLOR_W-1:0]);
		clut_rgb <= clut_mem[clut_idx];	// One cycle read
	end

endmodule

`default_nettype wire

// ==== design/rtg_pixel_timer.sv ====
//////////////////////////////////////////////////
// Pixel timing of the RTG path
// Fetch strobe, CLUT byte select, native divider
// and vblank stretched by vbend lines
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rtg_defs.svh"

module rtg_pixel_timer import rtg_pkg::*; (
	input  wire logic          CLK_114,
	input  wire logic          reset,
	input  wire rtg_ctrl_t     ctrl,
	input  wire native_video_t native,
	input  wire logic          low_res,	// Half native period
	output logic               fetch_strobe,	// Pop next word
	output logic               byte_sel,	// Low byte in CLUT mode
	output logic               rtg_blank,
	output logic               pixel_out	// Pixel strobe, one clock ahead of rgb
);

	localparam int DIV_W = $clog2(`NATIVE_DIV);

	logic [`PIXCTR_W-1:0] pixctr;	// Fetch clock
	logic [`VBCTR_W-1:0]  vb_ctr;	// Lines since vblank
	logic                 vb_ext;
	logic                 hsync_d;
	logic                 byte_sel_d;
	logic                 fetch_strobe_d;
	logic                 byte_rise;
	logic                 native_tick;
	logic [DIV_W-1:0]     native_ctr;
	logic [DIV_W-1:0]     native_last;

	assign rtg_blank    = native.hblank | native.vblank | vb_ext;
	assign fetch_strobe = ctrl.enable & ~rtg_blank & (pixctr == ctrl.pixel_width);
	assign byte_rise    = byte_sel & ~byte_sel_d;	// Second pixel of the word

	assign native_last = low_res ? DIV_W'(`NATIVE_DIV / 2 - 1) : DIV_W'(`NATIVE_DIV - 1);
	assign native_tick = (native_ctr == native_last);

	//////////////////////////////////////////////////
	// Fetch clock and byte select
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			pixctr   <= '0;
			byte_sel <= 1'b0;
		end else if (rtg_blank || fetch_strobe) begin
			pixctr   <= '0;	// Restart period
			byte_sel <= 1'b0;	// High byte first
		end else begin
			pixctr <= pixctr + 1'b1;
			if (pixctr == (ctrl.pixel_width >> 1))
				byte_sel <= 1'b1;	// Halfway
		end
	end

	//////////////////////////////////////////////////
	// Vblank extension
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			vb_ext  <= 1'b0;
			vb_ctr  <= '0;
			hsync_d <= 1'b0;
		end else begin
			hsync_d <= native.hsync;
			if (native.vblank) begin
				vb_ext <= 1'b1;
				vb_ctr <= '0;
			end else if (native.hsync && !hsync_d) begin
				if (vb_ctr == ctrl.vbend)
					vb_ext <= 1'b0;	// Line after the last hidden one
				else
					vb_ctr <= vb_ctr + 1'b1;	// Count each line start
			end
		end
	end

	//////////////////////////////////////////////////
	// Native divider and pixel strobe select
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			native_ctr     <= '0;
			byte_sel_d     <= 1'b0;
			fetch_strobe_d <= 1'b0;
			pixel_out      <= 1'b0;
		end else begin
			native_ctr     <= native_tick ? '0 : native_ctr + 1'b1;
			byte_sel_d     <= byte_sel;
			fetch_strobe_d <= fetch_strobe;
			if (!ctrl.enable)
				pixel_out <= native_tick;
			else if (ctrl.clut_mode)
				pixel_out <= fetch_strobe_d | byte_rise;	// Extra clock for palette read
			else
				pixel_out <= fetch_strobe;
		end
	end

endmodule

`default_nettype wire

// ==== design/rtg_fetch_fifo.sv ====
//////////////////////////////////////////////////
// Frame buffer fetch FIFO
// Streams words from the base address, reserves
// space per request, restarts on vblank or disable
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rtg_defs.svh"

module rtg_fetch_fifo import rtg_pkg::*; (
	input  wire logic                     CLK_114,
	input  wire logic                     reset,
	input  wire rtg_ctrl_t                ctrl,
	input  wire logic                     vblank,
	output logic                          mem_req_valid,
	input  wire logic                     mem_req_ready,
	output logic [`RTG_ADDR_W-1:0]        mem_req_addr,
	input  wire logic                     mem_rd_valid,	// In request order
	input  wire logic [`RTG_DATA_W-1:0]   mem_rd_data,
	input  wire logic                     fetch_strobe,	// Pop
	output logic [`RTG_DATA_W-1:0]        word	// Current display word
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 2;

	fetch_state_e state;
	logic [`RTG_DATA_W-1:0] fifo_mem [`FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;	// Words held
	logic [CNT_W-1:0] owed;	// Requests without response
	logic [CNT_W-1:0] drop;	// Stale responses still due
	logic [CNT_W-1:0] owed_next;
	logic [CNT_W-1:0] live;
	logic [`RTG_ADDR_W-1:0] next_addr;
	logic restart;
	logic xfer;
	logic issue;
	logic push;
	logic pop;

	assign restart   = vblank | ~ctrl.enable;
	assign xfer      = mem_req_valid & mem_req_ready;
	assign live      = owed - drop;	// Responses that will land here
	assign issue     = (state == FETCH_RUN) & ~restart & (~mem_req_valid | xfer) &
			   ((count + live) < CNT_W'(`FIFO_DEPTH));
	assign push      = mem_rd_valid & ~restart & (drop == '0);
	assign pop       = fetch_strobe & ~restart & (count != '0);	// Empty keeps last word
	assign owed_next = owed + CNT_W'(issue) - CNT_W'(mem_rd_valid);

	//////////////////////////////////////////////////
	// Request control and pointers
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			state         <= FETCH_IDLE;
			mem_req_valid <= 1'b0;
			next_addr     <= '0;
			owed          <= '0;
			drop          <= '0;
			count         <= '0;
			wr_ptr        <= '0;
			rd_ptr        <= '0;
		end else begin
			state <= restart ? FETCH_IDLE : FETCH_RUN;
			owed  <= owed_next;
			if (issue)
				mem_req_valid <= 1'b1;
			else if (xfer)
				mem_req_valid <= 1'b0;	// Held request stays until taken
			if (restart) begin
				next_addr <= ctrl.base;
				drop      <= owed_next;	// Everything in flight is stale
				count     <= '0;
				wr_ptr    <= '0;
				rd_ptr    <= '0;
			end else begin
				if (issue)
					next_addr <= next_addr + `RTG_ADDR_W'(2);
				if (mem_rd_valid && drop != '0)
					drop <= drop - 1'b1;
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				count <= count + CNT_W'(push) - CNT_W'(pop);
			end
		end
	end

	//////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (issue)
			mem_req_addr <= next_addr;
		if (push)
			fifo_mem[wr_ptr] <= mem_rd_data;
		if (pop)
			word <= fifo_mem[rd_ptr];	// Head word
	end

endmodule

`default_nettype wire

// ==== design/rtg_video_out.sv ====
//////////////////////////////////////////////////
// Video output stage of the RTG path
// High-colour or CLUT pixels, native fallback,
// OSD overlay and the registered outputs
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rtg_defs.svh"

module rtg_video_out import rtg_pkg::*; (
	input  wire logic                               CLK_114,
	input  wire logic                               reset,
	input  wire rtg_ctrl_t                          ctrl,
	input  wire logic [`RTG_DATA_W-1:0]             word,
	input  wire logic                               byte_sel,
	input  wire logic                               rtg_blank,
	input  wire logic                               pixel_out,
	input  wire native_video_t                      native,
	input  wire logic                               osd_window,
	input  wire logic                               osd_pixel,
	output logic [$clog2(`CLUT_ENTRIES)-1:0]        clut_idx,
	input  wire rgb_t                               clut_rgb,
	output rgb_t                                    rgb,
	output logic                                    hsync,
	output logic                                    vsync,
	output logic                                    csync,
	output logic                                    pixel_strobe
);

	logic       blank_d1;	// Lined up with word
	logic       blank_d2;	// Lined up with palette colour
	logic       rtg_show;
	logic [1:0] osd_rg;
	logic [1:0] osd_b;
	rgb_t       hc_rgb;
	rgb_t       base_rgb;
	rgb_t       osd_rgb;

	// OSD colour on top, picture shifted down
	function automatic logic [`COLOR_W-1:0] osd_mix(input logic [1:0] top,
							input logic [`COLOR_W-1:0] ch);
		return {top, ch[`COLOR_W-1:2]};
	endfunction

	assign clut_idx = byte_sel ? word[7:0] : word[15:8];	// High byte first

	// 5 bits per channel, top bits repeated
	assign hc_rgb.r = {word[14:10], word[14:12]};
	assign hc_rgb.g = {word[9:5], word[9:7]};
	assign hc_rgb.b = {word[4:0], word[4:2]};

	assign rtg_show = ctrl.enable & ~(ctrl.clut_mode ? blank_d2 : blank_d1);
	assign base_rgb = !rtg_show ? native.rgb : (ctrl.clut_mode ? clut_rgb : hc_rgb);

	assign osd_rg    = {2{osd_pixel}};	// White or black
	assign osd_b     = {1'b1, osd_pixel};	// Blue tint off pixel
	assign osd_rgb.r = osd_mix(osd_rg, base_rgb.r);
	assign osd_rgb.g = osd_mix(osd_rg, base_rgb.g);
	assign osd_rgb.b = osd_mix(osd_b, base_rgb.b);

	//////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			blank_d1     <= 1'b1;
			blank_d2     <= 1'b1;
			hsync        <= 1'b0;
			vsync        <= 1'b0;
			csync        <= 1'b0;
			pixel_strobe <= 1'b0;
		end else begin
			blank_d1     <= rtg_blank;
			blank_d2     <= blank_d1;
			hsync        <= native.hsync;
			vsync        <= native.vsync;
			csync        <= native.csync;
			pixel_strobe <= pixel_out;	// Same cycle as its colour
		end
	end

	always_ff @(posedge CLK_114) begin
		rgb <= osd_window ? osd_rgb : base_rgb;
	end

endmodule

`default_nettype wire

// ==== design/rtg_display_top.sv ====
//////////////////////////////////////////////////
// Top level of the RTG display path
// Config block, pixel timer, fetch FIFO and video
// output on one clock
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rtg_defs.svh"

module rtg_display_top import rtg_pkg::*; (
	input  wire logic                     CLK_114,
	input  wire logic                     reset,
	// Config port
	input  wire logic                     cfg_valid,
	input  wire cfg_write_t               cfg,
	// Chipset video and OSD
	input  wire native_video_t            native,
	input  wire logic                     low_res,
	input  wire logic                     osd_window,
	input  wire logic                     osd_pixel,
	// Memory port
	output logic                          mem_req_valid,
	input  wire logic                     mem_req_ready,
	output logic [`RTG_ADDR_W-1:0]        mem_req_addr,
	input  wire logic                     mem_rd_valid,
	input  wire logic [`RTG_DATA_W-1:0]   mem_rd_data,
	// Display
	output rgb_t                          rgb,
	output logic                          hsync,
	output logic                          vsync,
	output logic                          csync,
	output logic                          pixel_strobe
);

	rtg_ctrl_t ctrl;
	rgb_t clut_rgb;
	logic [$clog2(`CLUT_ENTRIES)-1:0] clut_idx;
	logic [`RTG_DATA_W-1:0] word;
	logic fetch_strobe;
	logic byte_sel;
	logic rtg_blank;
	logic pixel_out;

	rtg_config_regs regs0 (
		.CLK_114  (CLK_114),
		.reset    (reset),
		.cfg_valid(cfg_valid),
		.cfg      (cfg),
		.clut_idx (clut_idx),
		.ctrl     (ctrl),
		.clut_rgb (clut_rgb)
	);

	rtg_pixel_timer timer0 (
		.CLK_114     (CLK_114),
		.reset       (reset),
		.ctrl        (ctrl),
		.native      (native),
		.low_res     (low_res),
		.fetch_strobe(fetch_strobe),
		.byte_sel    (byte_sel),
		.rtg_blank   (rtg_blank),
		.pixel_out   (pixel_out)
	);

	rtg_fetch_fifo fifo0 (
		.CLK_114      (CLK_114),
		.reset        (reset),
		.ctrl         (ctrl),
		.vblank       (native.vblank),	// Restart each frame
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_addr (mem_req_addr),
		.mem_rd_valid (mem_rd_valid),
		.mem_rd_data  (mem_rd_data),
		.fetch_strobe (fetch_strobe),
		.word         (word)
	);

	rtg_video_out vout0 (
		.CLK_114     (CLK_114),
		.reset       (reset),
		.ctrl        (ctrl),
		.word        (word),
		.byte_sel    (byte_sel),
		.rtg_blank   (rtg_blank),
		.pixel_out   (pixel_out),
		.native      (native),
		.osd_window  (osd_window),
		.osd_pixel   (osd_pixel),
		.clut_idx    (clut_idx),
		.clut_rgb    (clut_rgb),
		.rgb         (rgb),
		.hsync       (hsync),
		.vsync       (vsync),
		.csync       (csync),
		.pixel_strobe(pixel_strobe)
	);

endmodule

`default_nettype wire

// ==== sim/rtg_display_tb.sv ====
//////////////////////////////////////////////////
// Testbench of the RTG display path
// Native video generator, memory model with stalls
// and pixel checks, data from sim/rtg_vectors.txt
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rtg_defs.svh"

module rtg_display_tb import rtg_pkg::*; ();

	localparam int LINE_CLKS    = 64;	// Native line
	localparam int HBLANK_CLKS  = 16;
	localparam int FRAME_LINES  = 20;
	localparam int VBLANK_LINES = 3;
	localparam int FRAME_CLKS   = LINE_CLKS * FRAME_LINES;
	localparam int TEST_FRAMES  = 11;	// Sync plus all phases
	localparam int LIMIT        = (TEST_FRAMES + 2) * FRAME_CLKS;
	localparam int FB_WORDS     = 32;	// Vector words per block
	localparam int PAL_AT       = 32;	// Palette colours in vec
	localparam int CFG_AT       = 48;	// Base, pixel width, vbend
	localparam int VEC_LEN      = 51;
	localparam int MODE_OFF     = 0;
	localparam int MODE_NATIVE  = 1;
	localparam int MODE_HC      = 2;
	localparam int MODE_CLUT    = 3;

	logic CLK_114;
	logic reset;
	logic cfg_valid;
	cfg_write_t cfg;
	native_video_t native;
	logic low_res;
	logic osd_window;
	logic osd_pixel;
	logic mem_req_valid;
	logic mem_req_ready;
	logic [`RTG_ADDR_W-1:0] mem_req_addr;
	logic mem_rd_valid;
	logic [`RTG_DATA_W-1:0] mem_rd_data;
	rgb_t rgb;
	logic hsync;
	logic vsync;
	logic csync;
	logic pixel_strobe;

	logic [31:0] vec [VEC_LEN];	// Vector file image
	int hcount;
	int vcount;
	int cycle;
	int mode;
	int hidden;	// Lines hidden by vblank extension
	int k;	// Pixel position since frame start
	int frame_pix;
	int clut_pixels;
	int strobes;
	int last_strobe;
	int stall;
	int base_w;
	logic armed;
	logic skip_first;
	logic osd_en;
	logic low_res_seen;
	logic prev_osd_win;
	logic prev_osd_pix;
	native_video_t prev_native;
	logic [`RTG_ADDR_W-1:0] req_addr_q [$];
	int req_due_q [$];

	rtg_display_top dut0 (.*);

	// Vector block repeated, block number folded in
	function automatic logic [15:0] fb_word(input int idx);
		return vec[idx % FB_WORDS][15:0] ^ 16'(idx / FB_WORDS) ^ 16'(idx >> 21);
	endfunction

	// 5-bit level scaled to 8 bits
	function automatic logic [7:0] widen5(input int v);
		return 8'(v * 8 + v / 4);
	endfunction

	function automatic rgb_t expand_hc(input logic [15:0] w);
		rgb_t c;
		int v;
		v = int'(w);
		c.r = widen5((v / 1024) % 32);
		c.g = widen5((v / 32) % 32);
		c.b = widen5(v % 32);
		return c;
	endfunction

	function automatic rgb_t palette_colour(input int i);
		logic [7:0] b;
		b = 8'(i);
		return rgb_t'(vec[PAL_AT + (i % 16)][23:0] ^ {b, b, b});	// Unique per index
	endfunction

	function automatic rgb_t osd_over(input rgb_t c, input logic pix);
		rgb_t o;
		o.r = {pix, pix, c.r[7:2]};
		o.g = {pix, pix, c.g[7:2]};
		o.b = {1'b1, pix, c.b[7:2]};
		return o;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, want);
			$display("Something failed");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	task automatic cfg_write(input cfg_reg_e a, input logic [31:0] d);
		@(posedge CLK_114);
		cfg_valid <= 1'b1;
		cfg.addr  <= a;
		cfg.data  <= d;
	endtask

	task automatic cfg_done();
		@(posedge CLK_114);
		cfg_valid <= 1'b0;
		repeat (4) @(posedge CLK_114);	// Let native strobes drain
	endtask

	task automatic wait_boundary();
		@(negedge CLK_114);
		while (!(vcount == 1 && hcount == 0))
			@(negedge CLK_114);
	endtask

	task automatic start_mode(input int m, input int h);
		mode       = m;
		hidden     = h;
		k          = 0;
		frame_pix  = 0;
		skip_first = 1'b1;
		armed      = (m == MODE_HC);
	endtask

	initial begin
		CLK_114 = 1'b0;
		forever #5 CLK_114 = ~CLK_114;
	end

	//////////////////////////////////////////////////
	// Native video, 64-clock lines, 20-line frames
	//////////////////////////////////////////////////
	always @(posedge CLK_114) begin : video_gen
		int nh;
		int nv;
		nh = (hcount == LINE_CLKS - 1) ? 0 : hcount + 1;
		nv = vcount;
		if (hcount == LINE_CLKS - 1)
			nv = (vcount == FRAME_LINES - 1) ? 0 : vcount + 1;
		hcount         <= nh;
		vcount         <= nv;
		native.hblank  <= (nh < HBLANK_CLKS);
		native.vblank  <= (nv < VBLANK_LINES);
		native.hsync   <= (nh >= 2 && nh < 8);	// Inside hblank
		native.vsync   <= (nv == 0);
		native.csync   <= (nh >= 2 && nh < 8) || (nv == 0);
		native.rgb.r   <= 8'(nh * 4);
		native.rgb.g   <= 8'(nv * 12 + nh);
		native.rgb.b   <= 8'(nh * 7 + nv * 29);
		osd_window     <= osd_en && nh >= 20 && nh < 44;
		osd_pixel      <= ((nh / 2 + nv) % 2) == 1;
	end

	//////////////////////////////////////////////////
	// Memory model, random stalls, 2 to 5 clock reads
	//////////////////////////////////////////////////
	always @(posedge CLK_114) begin : mem_model
		if (mem_req_valid && mem_req_ready) begin
			req_addr_q.push_back(mem_req_addr);
			req_due_q.push_back(cycle + 2 + int'($urandom % 4));
		end
		if (req_due_q.size() > 0 && req_due_q[0] <= cycle) begin
			mem_rd_valid <= 1'b1;
			mem_rd_data  <= fb_word(int'(req_addr_q[0][`RTG_ADDR_W-1:1]));
			void'(req_addr_q.pop_front());
			void'(req_due_q.pop_front());
		end else begin
			mem_rd_valid <= 1'b0;
		end
		if (stall >= 3 || ($urandom % 2) == 1) begin
			mem_req_ready <= 1'b1;	// Grant at least every fourth
			stall = 0;
		end else begin
			mem_req_ready <= 1'b0;
			stall++;
		end
	end

	always @(posedge CLK_114) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("Timeout: no result after %0d clock cycles", LIMIT);
			$display("Something failed");
			$fatal(1, "Run timed out");
		end
	end

	//////////////////////////////////////////////////
	// Output checks, on the falling edge
	//////////////////////////////////////////////////
	always @(negedge CLK_114) begin : out_check
		rgb_t want;
		logic [15:0] w;
		logic [7:0] b;
		logic ext_line;
		int lines;
		if (vcount == 1 && hcount == 0) begin	// Frame boundary in vblank
			lines = FRAME_LINES - VBLANK_LINES - hidden;
			if (armed && mode == MODE_HC)
				check("pixels in frame", 32'(frame_pix),
					32'(lines * (LINE_CLKS - HBLANK_CLKS) / (vec[CFG_AT + 1] + 1)));
			frame_pix  = 0;
			k          = 0;
			skip_first = 1'b1;
		end
		if (low_res != low_res_seen || mode != MODE_NATIVE)
			strobes = 0;
		low_res_seen = low_res;
		ext_line = (vcount >= VBLANK_LINES && vcount < VBLANK_LINES + hidden);
		case (mode)
			MODE_NATIVE: begin
				want = prev_osd_win ? osd_over(prev_native.rgb, prev_osd_pix) : prev_native.rgb;
				check("native colour", 32'(rgb), 32'(want));
				check("hsync", 32'(hsync), 32'(prev_native.hsync));
				check("vsync", 32'(vsync), 32'(prev_native.vsync));
				check("csync", 32'(csync), 32'(prev_native.csync));
				if (pixel_strobe) begin
					if (strobes >= 2)
						check("native pixel period", 32'(cycle - last_strobe),
							low_res ? `NATIVE_DIV / 2 : `NATIVE_DIV);
					strobes++;
					last_strobe = cycle;
				end
			end
			MODE_HC: begin
				if (ext_line) begin
					check("strobe in extended vblank", 32'(pixel_strobe), 0);
					check("colour in extended vblank", 32'(rgb), 32'(prev_native.rgb));
				end
				if (pixel_strobe) begin
					w = fb_word(base_w + k);
					check("high-colour pixel", 32'(rgb), 32'(expand_hc(w)));
					k++;
					frame_pix++;
				end
			end
			MODE_CLUT: begin
				if (pixel_strobe && skip_first) begin
					skip_first = 1'b0;	// Low byte of the previous frame
				end else if (pixel_strobe) begin
					w = fb_word(base_w + k / 2);
					b = (k % 2 == 0) ? w[15:8] : w[7:0];	// High byte first
					check("palette pixel", 32'(rgb), 32'(palette_colour(b)));
					k++;
					clut_pixels++;
				end
			end
			default: begin
			end
		endcase
		prev_native  = native;
		prev_osd_win = osd_window;
		prev_osd_pix = osd_pixel;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		void'($urandom(56));
		$readmemh("sim/rtg_vectors.txt", vec);
		reset = 1'b1;
		cfg_valid = 1'b0;
		cfg = '0;
		native = '0;
		low_res = 1'b0;
		osd_window = 1'b0;
		osd_pixel = 1'b0;
		osd_en = 1'b0;
		mem_req_ready = 1'b0;
		mem_rd_valid = 1'b0;
		mem_rd_data = '0;
		hcount = LINE_CLKS - 1;
		vcount = FRAME_LINES - 1;
		cycle = 0;
		stall = 0;
		clut_pixels = 0;
		strobes = 0;
		last_strobe = 0;
		low_res_seen = 1'b0;
		prev_native = '0;
		prev_osd_win = 1'b0;
		prev_osd_pix = 1'b0;
		base_w = int'(vec[CFG_AT][`RTG_ADDR_W-1:1]);
		start_mode(MODE_OFF, 0);
		repeat (3) @(posedge CLK_114);
		reset <= 1'b0;

		// RTG off, palette loaded meanwhile
		wait_boundary();
		for (int i = 0; i < `CLUT_ENTRIES; i++)
			cfg_write(CFG_CLUT, {8'(i), 24'(palette_colour(i))});
		cfg_done();
		start_mode(MODE_NATIVE, 0);
		wait_boundary();
		@(posedge CLK_114);
		low_res <= 1'b1;
		wait_boundary();
		@(posedge CLK_114);
		low_res <= 1'b0;

		// High colour, two frames so the restart is seen
		start_mode(MODE_OFF, 0);
		cfg_write(CFG_BASE, vec[CFG_AT]);
		cfg_write(CFG_PIXEL_WIDTH, vec[CFG_AT + 1]);
		cfg_write(CFG_VBEND, 0);
		cfg_write(CFG_CONTROL, 32'h1);
		cfg_done();
		start_mode(MODE_HC, 0);
		repeat (2) wait_boundary();

		@(posedge CLK_114);
		start_mode(MODE_OFF, 0);
		cfg_write(CFG_CONTROL, 32'h3);
		cfg_done();
		start_mode(MODE_CLUT, 0);
		repeat (2) wait_boundary();

		// Vblank stretched by vbend lines
		@(posedge CLK_114);
		start_mode(MODE_OFF, 0);
		cfg_write(CFG_VBEND, vec[CFG_AT + 2]);
		cfg_write(CFG_CONTROL, 32'h1);
		cfg_done();
		start_mode(MODE_HC, int'(vec[CFG_AT + 2]));
		repeat (2) wait_boundary();

		@(posedge CLK_114);
		start_mode(MODE_OFF, 0);
		cfg_write(CFG_CONTROL, 32'h0);
		cfg_done();
		osd_en <= 1'b1;
		start_mode(MODE_NATIVE, 0);
		wait_boundary();

		check("palette pixels seen", 32'(clut_pixels > 0), 1);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/rtg_vectors.txt ====
// Words 00..1f: frame buffer, wraps every 32 words (bit 15 unused in high colour)
// Words 20..2f: palette colours RRGGBB, 30..32: base byte address, pixel width, vbend
@00
// Frame buffer
7fff 0000 7c00 03e0 001f 4210 2108 5294
1234 6bde 0f0f 70f0 3c1e 03ff 7e00 01ef
a5a5 5a5a 1357 2468 0a0b 7b7c 300c 4c31
0001 7ffe 5555 2aaa 6666 1999 3f3f 4040
@20
// Palette colours
000000 ffffff ff0000 00ff00 0000ff ffff00 00ffff ff00ff
808080 c04020 2080c0 40c080 123456 654321 abcdef fedcba
@30
// Base byte address, pixel width, vbend
00000050 00000003 00000002

// ==== rtg_display.f ====
+incdir+design
design/rtg_pkg.sv
design/rtg_config_regs.sv
design/rtg_pixel_timer.sv
design/rtg_fetch_fifo.sv
design/rtg_video_out.sv
design/rtg_display_top.sv
sim/rtg_display_tb.sv

// ==== Makefile ====
# Verilator build of the RTG display path
TOP = rtg_display_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f rtg_display.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f rtg_display.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
